// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_simd_top
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/simd_checker.sv ====
/*
 * Scoreboard for the SIMD lane unit testbench.
 * Records each transaction at the rise of in_ack, predicts the result
 * vector and compares it with out_data at the rise of out_req.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module simd_checker
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_ack,
  input  logic [`SIMD_VEC_W-1:0] in_a,
  input  logic [`SIMD_VEC_W-1:0] in_b,
  input  prec_t                  in_prec,
  input  lane_op_t               in_op,
  input  logic                   out_req,
  input  logic [`SIMD_VEC_W-1:0] out_data,
  output int                     err_cnt,
  output int                     chk_cnt,
  output int                     pend_cnt
);

  typedef logic [`SIMD_WORD_W-1:0] word_t;
  typedef logic [`SIMD_VEC_W-1:0]  vec_t;

  vec_t  exp_q[$];
  prec_t prec_q[$];
  vec_t  exp_v;
  prec_t exp_p;
  int    errors   = 0;
  int    checks   = 0;
  int    pending  = 0;
  logic  ack_q    = 1'b0;
  logic  req_q    = 1'b0;
  logic  rst_q    = 1'b0;
  logic  rst_seen = 1'b0;

  assign err_cnt  = errors;
  assign chk_cnt  = checks;
  assign pend_cnt = pending;

  function automatic int elem_width(input prec_t p);
    case (p)
      INT8:    return 8;
      INT16:   return 16;
      INT32:   return 32;
      default: return `SIMD_WORD_W;
    endcase
  endfunction

  // element j of both vectors, operate, cut to width, put back at element j
  function automatic vec_t expected_vec(input vec_t a, input vec_t b,
                                        input prec_t p, input lane_op_t op);
    int    ew;
    word_t mask;
    word_t ea;
    word_t eb;
    word_t r;
    vec_t  res;
    ew   = elem_width(p);
    mask = (ew == `SIMD_WORD_W) ? {`SIMD_WORD_W{1'b1}} : ((word_t'(1) << ew) - word_t'(1));
    res  = '0;
    for (int j = 0; j < `SIMD_LANES; j++) begin
      ea = word_t'(a >> (j * ew)) & mask;
      eb = word_t'(b >> (j * ew)) & mask;
      case (op)
        OP_ADD:  r = ea + eb;
        OP_SUB:  r = ea - eb;
        OP_MUL:  r = ea * eb;
        default: r = (ea > eb) ? ea : eb;
      endcase
      res = res | (vec_t'(r & mask) << (j * ew));
    end
    return res;
  endfunction

  task automatic value_error(input string name, input vec_t exp, input vec_t act);
    errors++;
    $display("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
  endtask

  always @(posedge clk) begin
    // reset values hold from the second reset edge until one edge after release
    if ((!rst_n || !rst_q) && rst_seen) begin
      if (in_ack !== 1'b0) value_error("in_ack", '0, vec_t'(in_ack));
      if (out_req !== 1'b0) value_error("out_req", '0, vec_t'(out_req));
    end
    if (!rst_n) rst_seen = 1'b1;
    if (rst_n && in_ack && !ack_q) begin
      exp_q.push_back(expected_vec(in_a, in_b, in_prec, in_op));
      prec_q.push_back(in_prec);
    end
    if (rst_n && out_req && !req_q) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("out_req rose at %0t ns with no accepted transaction waiting", $time);
      end else begin
        exp_v = exp_q.pop_front();
        exp_p = prec_q.pop_front();
        checks++;
        if (out_data !== exp_v) value_error("out_data", exp_v, out_data);
        if ((out_data >> (`SIMD_LANES * elem_width(exp_p))) != '0) begin
          value_error("out_data upper bits", '0,
                      out_data >> (`SIMD_LANES * elem_width(exp_p)));
        end
      end
    end
    ack_q   = in_ack;
    req_q   = out_req;
    rst_q   = rst_n;
    pending = exp_q.size();
  end

endmodule

// ==== bench/tb_simd_top.sv ====
/*
 * Testbench for the SIMD lane unit.
 * Runs the input handshake with seeded random operands, acknowledges
 * results after random delays and reports each test in turn.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module tb_simd_top
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
();

  localparam int RST_CYCLES  = 10;
  localparam int N_RAND      = 100;
  localparam int N_TOTAL     = 4 * 8 + 2 * 4 * 6 + 4 * 6 + 3 * 6 + N_RAND;
  localparam int TIMEOUT_CYC = N_TOTAL * 40 + RST_CYCLES;
  localparam int DRAIN_CYC   = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   in_req;
  logic [`SIMD_VEC_W-1:0] in_a;
  logic [`SIMD_VEC_W-1:0] in_b;
  prec_t                  in_prec;
  lane_op_t               in_op;
  logic                   in_ack;
  logic                   out_req;
  logic [`SIMD_VEC_W-1:0] out_data;
  logic                   out_ack;
  int                     err_cnt;
  int                     chk_cnt;
  int                     pend_cnt;
  int                     bench_fails = 0;
  int                     errs_start  = 0;
  int                     chk_start   = 0;

  simd_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_prec  (in_prec),
    .in_op    (in_op),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  simd_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_ack   (in_ack),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_prec  (in_prec),
    .in_op    (in_op),
    .out_req  (out_req),
    .out_data (out_data),
    .err_cnt  (err_cnt),
    .chk_cnt  (chk_cnt),
    .pend_cnt (pend_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // stimulus helpers
  // ====================
  task automatic send(input prec_t p, input lane_op_t op);
    logic [`SIMD_VEC_W-1:0] a;
    logic [`SIMD_VEC_W-1:0] b;
    for (int i = 0; i < `SIMD_VEC_W / 32; i++) begin
      a[i*32 +: 32] = $urandom;
      b[i*32 +: 32] = $urandom;
    end
    @(negedge clk);
    in_a    = a;
    in_b    = b;
    in_prec = p;
    in_op   = op;
    in_req  = 1'b1;
    do @(negedge clk); while (!in_ack);
    in_req = 1'b0;
    do @(negedge clk); while (in_ack);
  endtask

  // wait for outstanding results, then report the test
  task automatic close_test(input string name);
    int waited;
    int errs;
    waited = 0;
    while ((pend_cnt != 0 || out_req || out_ack) && waited < DRAIN_CYC) begin
      @(negedge clk);
      waited++;
    end
    if (pend_cnt != 0) begin
      bench_fails++;
      $display("%s: %0d results never came back from the DUT", name, pend_cnt);
    end
    errs = err_cnt + bench_fails;
    if (errs == errs_start) begin
      $display("test %s: passed, %0d results checked", name, chk_cnt - chk_start);
    end else begin
      $display("test %s: failed with %0d errors", name, errs - errs_start);
    end
    errs_start = errs;
    chk_start  = chk_cnt;
  endtask

  // sink side, ack after 0 to 5 cycles
  initial begin
    int delay;
    out_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && out_req && !out_ack) begin
        delay = $urandom_range(0, 5);
        repeat (delay) @(negedge clk);
        out_ack = 1'b1;
        do @(negedge clk); while (out_req);
        out_ack = 1'b0;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles, handshake stuck", TIMEOUT_CYC);
    $display("RESULT: FAIL");
    $finish;
  end

  // ====================
  // test sequence
  // ====================
  initial begin
    void'($urandom(32'hd079ad3b));
    rst_n   = 1'b0;
    in_req  = 1'b0;
    in_a    = '0;
    in_b    = '0;
    in_prec = INT8;
    in_op   = OP_ADD;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    close_test("reset");

    for (int p = 0; p < 4; p++) repeat (8) send(prec_t'(p), OP_ADD);
    close_test("add all precisions");

    for (int p = 0; p < 4; p++) begin
      repeat (6) send(prec_t'(p), OP_SUB);
      repeat (6) send(prec_t'(p), OP_MUL);
    end
    close_test("sub and mul wrap");

    for (int p = 0; p < 4; p++) repeat (6) send(prec_t'(p), OP_MAX);
    close_test("max");

    // narrow precisions, upper vector bits checked on every result
    for (int p = 0; p < 3; p++) repeat (6) send(prec_t'(p), lane_op_t'($urandom_range(0, 3)));
    close_test("upper bits zero");

    repeat (N_RAND) send(prec_t'($urandom_range(0, 3)), lane_op_t'($urandom_range(0, 3)));
    close_test("order under back-pressure");

    $display("%0d results checked, %0d errors", chk_cnt, err_cnt + bench_fails);
    if (err_cnt + bench_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/simd_prec_pkg.sv
rtl/simd_op_pkg.sv
rtl/operand_capture.sv
rtl/filter_and_select.sv
rtl/lane_alu.sv
rtl/result_pack.sv
rtl/simd_top.sv
bench/simd_checker.sv
bench/tb_simd_top.sv

// ==== rtl/filter_and_select.sv ====
/*
 * Unpack stage of the SIMD lane unit.
 * Spreads the packed elements of each operand across the lanes,
 * element j into lane j, zero-extended to a full word.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module filter_and_select
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cap_valid,
  input  logic [`SIMD_VEC_W-1:0] cap_a,
  input  logic [`SIMD_VEC_W-1:0] cap_b,
  input  prec_t                  cap_prec,
  input  lane_op_t               cap_op,
  output logic                   cap_stall,
  output logic                   unp_valid,
  output logic [`SIMD_VEC_W-1:0] unp_a,
  output logic [`SIMD_VEC_W-1:0] unp_b,
  output prec_t                  unp_prec,
  output lane_op_t               unp_op,
  input  logic                   unp_stall
);

  localparam int W = `SIMD_WORD_W;
  localparam int L = `SIMD_LANES;

  logic load;

  // element j at the chosen width goes to the low bits of lane j
  function automatic logic [`SIMD_VEC_W-1:0] unpack(input logic [`SIMD_VEC_W-1:0] v,
                                                    input prec_t p);
    logic [`SIMD_VEC_W-1:0] r;
    r = '0;
    for (int j = 0; j < L; j++) begin
      case (p)
        INT8:    r[j*W +: 8]  = v[j*8 +: 8];
        INT16:   r[j*W +: 16] = v[j*16 +: 16];
        INT32:   r[j*W +: 32] = v[j*32 +: 32];
        default: r[j*W +: W]  = v[j*W +: W];
      endcase
    end
    return r;
  endfunction

  assign cap_stall = unp_valid && unp_stall;
  assign load      = cap_valid && !cap_stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      unp_valid <= 1'b0;
    end else if (!cap_stall) begin
      unp_valid <= cap_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      unp_a    <= unpack(cap_a, cap_prec);
      unp_b    <= unpack(cap_b, cap_prec);
      unp_prec <= cap_prec;
      unp_op   <= cap_op;
    end
  end

  // capture stage must hand over a defined precision
  a_prec_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    cap_valid |-> !$isunknown(cap_prec)
  );

endmodule

// ==== rtl/lane_alu.sv ====
/*
 * Arithmetic stage of the SIMD lane unit.
 * Every lane applies the same unsigned opcode to its pair of
 * elements and keeps only the low element-width bits.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module lane_alu
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   unp_valid,
  input  logic [`SIMD_VEC_W-1:0] unp_a,
  input  logic [`SIMD_VEC_W-1:0] unp_b,
  input  prec_t                  unp_prec,
  input  lane_op_t               unp_op,
  output logic                   unp_stall,
  output logic                   alu_valid,
  output logic [`SIMD_VEC_W-1:0] alu_res,
  output prec_t                  alu_prec,
  input  logic                   alu_stall
);

  localparam int W = `SIMD_WORD_W;
  localparam int L = `SIMD_LANES;

  logic                   load;
  logic [`SIMD_VEC_W-1:0] alu_next;

  function automatic logic [W-1:0] elem_mask(input prec_t p);
    case (p)
      INT8:    return {{(W-8){1'b0}}, {8{1'b1}}};
      INT16:   return {{(W-16){1'b0}}, {16{1'b1}}};
      INT32:   return {{(W-32){1'b0}}, {32{1'b1}}};
      default: return {W{1'b1}};
    endcase
  endfunction

  // mul keeps the low word, the mask then cuts to element width
  function automatic logic [W-1:0] lane_op(input lane_op_t op,
                                           input logic [W-1:0] a,
                                           input logic [W-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MUL:  return a * b;
      default: return (a > b) ? a : b;
    endcase
  endfunction

  always_comb begin
    for (int j = 0; j < L; j++) begin
      alu_next[j*W +: W] = lane_op(unp_op, unp_a[j*W +: W], unp_b[j*W +: W])
                           & elem_mask(unp_prec);
    end
  end

  assign unp_stall = alu_valid && alu_stall;
  assign load      = unp_valid && !unp_stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_valid <= 1'b0;
    end else if (!unp_stall) begin
      alu_valid <= unp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      alu_res  <= alu_next;
      alu_prec <= unp_prec;
    end
  end

endmodule

// ==== rtl/operand_capture.sv ====
/*
 * Input stage of the SIMD lane unit.
 * Receives one transaction over a four-phase req/ack handshake
 * and holds it until the unpack stage takes it.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module operand_capture
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_req,
  input  logic [`SIMD_VEC_W-1:0] in_a,
  input  logic [`SIMD_VEC_W-1:0] in_b,
  input  prec_t                  in_prec,
  input  lane_op_t               in_op,
  output logic                   in_ack,
  output logic                   cap_valid,
  output logic [`SIMD_VEC_W-1:0] cap_a,
  output logic [`SIMD_VEC_W-1:0] cap_b,
  output prec_t                  cap_prec,
  output lane_op_t               cap_op,
  input  logic                   cap_stall
);

  hs_state_t state;
  logic      cap_free;
  logic      load;

  // register free when empty or its item leaves this cycle
  assign cap_free = !cap_valid || !cap_stall;
  assign load     = (state == IDLE) && in_req && cap_free;

  // ====================
  // handshake machine
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      in_ack    <= 1'b0;
      cap_valid <= 1'b0;
    end else begin
      if (load) begin
        cap_valid <= 1'b1;
      end else if (!cap_stall) begin
        cap_valid <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (load) begin
            in_ack <= 1'b1;
            state  <= BUSY;
          end
        end
        BUSY: begin
          // wait for the source to drop req
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cap_a    <= in_a;
      cap_b    <= in_b;
      cap_prec <= in_prec;
      cap_op   <= in_op;
    end
  end

  a_ack_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> $past(in_req)
  );

endmodule

// ==== rtl/result_pack.sv ====
/*
 * Output stage of the SIMD lane unit.
 * Packs lane results back into element positions 0..LANES-1,
 * zeroes the rest and offers the vector over a four-phase
 * req/ack handshake. Holds the pipeline until ack has dropped.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module result_pack
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   alu_valid,
  input  logic [`SIMD_VEC_W-1:0] alu_res,
  input  prec_t                  alu_prec,
  output logic                   alu_stall,
  output logic                   out_req,
  output logic [`SIMD_VEC_W-1:0] out_data,
  input  logic                   out_ack
);

  localparam int W = `SIMD_WORD_W;
  localparam int L = `SIMD_LANES;

  hs_state_t              state;
  logic                   load;
  logic [`SIMD_VEC_W-1:0] pack_next;

  // low element bits of lane j land at element position j
  function automatic logic [`SIMD_VEC_W-1:0] pack(input logic [`SIMD_VEC_W-1:0] v,
                                                  input prec_t p);
    logic [`SIMD_VEC_W-1:0] r;
    r = '0;
    for (int j = 0; j < L; j++) begin
      case (p)
        INT8:    r[j*8 +: 8]   = v[j*W +: 8];
        INT16:   r[j*16 +: 16] = v[j*W +: 16];
        INT32:   r[j*32 +: 32] = v[j*W +: 32];
        default: r[j*W +: W]   = v[j*W +: W];
      endcase
    end
    return r;
  endfunction

  assign pack_next = pack(alu_res, alu_prec);

  // free when empty, or once the sink has dropped ack
  assign alu_stall = !((state == IDLE) || ((state == RELEASE) && !out_ack));
  assign load      = alu_valid && !alu_stall;

  // ====================
  // output handshake
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (load) begin
            out_req <= 1'b1;
            state   <= BUSY;
          end
        end
        BUSY: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= RELEASE;
          end
        end
        RELEASE: begin
          // next item may go out as soon as ack is low
          if (load) begin
            out_req <= 1'b1;
            state   <= BUSY;
          end else if (!out_ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= pack_next;
    end
  end

  a_data_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_req |=> !out_req || $stable(out_data)
  );

endmodule

// ==== rtl/simd_macros.svh ====
/*
 * Lane count and word width for the SIMD lane unit.
 * Included by every RTL module and by the bench.
 */
`ifndef SIMD_MACROS_SVH
`define SIMD_MACROS_SVH

// number of lanes, also words per operand vector
`define SIMD_LANES 4

// one word, one lane
`define SIMD_WORD_W 64

`define SIMD_VEC_W (`SIMD_LANES * `SIMD_WORD_W)

`endif

// ==== rtl/simd_op_pkg.sv ====
/*
 * Lane opcodes and handshake states of the SIMD lane unit.
 * All lane arithmetic is unsigned.
 */
package simd_op_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_MAX = 2'd3
  } lane_op_t;

  // four-phase machine states, used by input and output sides
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    BUSY    = 2'd1,
    RELEASE = 2'd2
  } hs_state_t;

endpackage

// ==== rtl/simd_prec_pkg.sv ====
/*
 * Precision codes of the SIMD lane unit.
 * The code selects the element width used for unpack,
 * truncation and pack. Import by wildcard where needed.
 */
package simd_prec_pkg;

  // element width per code
  // INT8 8 bits, INT16 16 bits, INT32 32 bits, INT64 a full word
  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    INT32 = 2'd2,
    INT64 = 2'd3
  } prec_t;

endpackage

// ==== rtl/simd_top.sv ====
/*
 * Top level of the SIMD lane unit.
 * Capture, unpack, lane arithmetic and pack stages in a chain,
 * four-phase handshakes on both ends.
 */
`timescale 1ns/1ns
`include "simd_macros.svh"

module simd_top
  import simd_prec_pkg::*;
  import simd_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_req,
  input  logic [`SIMD_VEC_W-1:0] in_a,
  input  logic [`SIMD_VEC_W-1:0] in_b,
  input  prec_t                  in_prec,
  input  lane_op_t               in_op,
  output logic                   in_ack,
  output logic                   out_req,
  output logic [`SIMD_VEC_W-1:0] out_data,
  input  logic                   out_ack
);

  // capture to unpack
  logic                   cap_valid;
  logic                   cap_stall;
  logic [`SIMD_VEC_W-1:0] cap_a;
  logic [`SIMD_VEC_W-1:0] cap_b;
  prec_t                  cap_prec;
  lane_op_t               cap_op;

  // unpack to alu
  logic                   unp_valid;
  logic                   unp_stall;
  logic [`SIMD_VEC_W-1:0] unp_a;
  logic [`SIMD_VEC_W-1:0] unp_b;
  prec_t                  unp_prec;
  lane_op_t               unp_op;

  // alu to pack
  logic                   alu_valid;
  logic                   alu_stall;
  logic [`SIMD_VEC_W-1:0] alu_res;
  prec_t                  alu_prec;

  operand_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_prec   (in_prec),
    .in_op     (in_op),
    .in_ack    (in_ack),
    .cap_valid (cap_valid),
    .cap_a     (cap_a),
    .cap_b     (cap_b),
    .cap_prec  (cap_prec),
    .cap_op    (cap_op),
    .cap_stall (cap_stall)
  );

  filter_and_select u_unpack (
    .clk       (clk),
    .rst_n     (rst_n),
    .cap_valid (cap_valid),
    .cap_a     (cap_a),
    .cap_b     (cap_b),
    .cap_prec  (cap_prec),
    .cap_op    (cap_op),
    .cap_stall (cap_stall),
    .unp_valid (unp_valid),
    .unp_a     (unp_a),
    .unp_b     (unp_b),
    .unp_prec  (unp_prec),
    .unp_op    (unp_op),
    .unp_stall (unp_stall)
  );

  lane_alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .unp_valid (unp_valid),
    .unp_a     (unp_a),
    .unp_b     (unp_b),
    .unp_prec  (unp_prec),
    .unp_op    (unp_op),
    .unp_stall (unp_stall),
    .alu_valid (alu_valid),
    .alu_res   (alu_res),
    .alu_prec  (alu_prec),
    .alu_stall (alu_stall)
  );

  result_pack u_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_valid (alu_valid),
    .alu_res   (alu_res),
    .alu_prec  (alu_prec),
    .alu_stall (alu_stall),
    .out_req   (out_req),
    .out_data  (out_data),
    .out_ack   (out_ack)
  );

endmodule
